// File: flist.f
src/cpu_pkg.sv
src/cpu_alu.sv
src/cpu_core.sv
src/bus_bridge.sv
src/cpu_handler_top.sv
tests/frame_checker.sv
tests/tb_cpu_handler.sv

// File: src/bus_bridge.sv
// Byte-serial bus bridge
`timescale 1ns/100ps

module bus_bridge (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              req,
  output logic              ack,
  input  cpu_pkg::bus_req_t bus_req,
  output cpu_pkg::bus_rsp_t bus_rsp,
  input  logic              halted,
  output logic [7:0]        uo_out,
  output logic [7:0]        uio_out,
  output logic [7:0]        uio_oe,
  input  logic [7:0]        uio_in
);
  import cpu_pkg::*;

  frame_phase_e phase;
  logic [1:0] beat;  // Beat within address or read phase
  logic [31:0] addr_sr;  // Address bytes, low byte first
  logic [31:0] wdata_sr;
  logic write_q;
  logic [31:0] rdata_q;
  logic [7:0] idle_byte;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      phase <= PH_IDLE;
      beat <= '0;
    end else begin
      case (phase)
        PH_IDLE: begin
          if (req) begin
            phase <= PH_START;
          end
        end
        PH_START: begin
          phase <= PH_ADDR;
          beat <= '0;
        end
        PH_ADDR: begin
          beat <= beat + 2'd1;
          if (beat == BEAT_LAST) begin
            phase <= PH_CMD;
          end
        end
        PH_CMD: begin
          phase <= PH_READ;
        end
        PH_READ: begin
          beat <= beat + 2'd1;
          if (beat == BEAT_LAST) begin
            phase <= PH_ACK;  // Ack follows last read beat
          end
        end
        PH_ACK: begin
          if (!req) begin
            phase <= PH_IDLE;
          end
        end
        default: begin
          phase <= PH_IDLE;
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (phase == PH_IDLE && req) begin
      addr_sr <= bus_req.addr;  // Latch whole request at frame start
      wdata_sr <= bus_req.wdata;
      write_q <= bus_req.write;
      rdata_q <= '0;
    end
    if (phase == PH_ADDR) begin
      addr_sr <= {8'h00, addr_sr[31:8]};
      wdata_sr <= {8'h00, wdata_sr[31:8]};
    end
    // Byte 0 arrives first and ends up at the bottom
    if (phase == PH_READ && !write_q) begin
      rdata_q <= {uio_in, rdata_q[31:8]};
    end
  end

  assign idle_byte = halted ? IDLE_HALT : IDLE_RUN;

  always_comb begin
    uo_out = idle_byte;
    uio_out = 8'h00;
    uio_oe = 8'h00;
    case (phase)
      PH_START: begin
        uo_out = FRAME_START;
      end
      PH_ADDR: begin
        uo_out = addr_sr[7:0];
        uio_out = wdata_sr[7:0];
        uio_oe = {8{write_q}};  // Drive uio only for writes
      end
      PH_CMD: begin
        uo_out = 8'h00;
        uo_out[CMD_WRITE_BIT] = write_q;
      end
      default: begin
        uo_out = idle_byte;
      end
    endcase
  end

  assign ack = (phase == PH_ACK);
  assign bus_rsp.rdata = rdata_q;

endmodule

// File: src/cpu_alu.sv
// Accumulator ALU
`timescale 1ns/100ps

module cpu_alu (
  input  cpu_pkg::opcode_e op,
  input  logic [31:0]      acc,
  input  logic [31:0]      operand,
  output logic [31:0]      result
);
  import cpu_pkg::*;

  always_comb begin
    case (op)
      OP_LOAD: begin
        result = operand;  // Plain load replaces accumulator
      end
      OP_ADD: begin
        result = acc + operand;
      end
      OP_SUB: begin
        result = acc - operand;
      end
      OP_AND: begin
        result = acc & operand;
      end
      OP_XOR: begin
        result = acc ^ operand;
      end
      default: begin
        result = acc;  // Store and others keep accumulator
      end
    endcase
  end

endmodule

// File: src/cpu_core.sv
// Accumulator CPU core
`timescale 1ns/100ps

module cpu_core (
  input  logic              clk,
  input  logic              rst_n,
  output logic              req,
  input  logic              ack,
  output cpu_pkg::bus_req_t bus_req,
  input  cpu_pkg::bus_rsp_t bus_rsp,
  output logic              halted
);
  import cpu_pkg::*;

  typedef enum logic [2:0] {
    ST_FETCH,  // Instruction request outstanding
    ST_FETCH_REL,  // Wait for ack to drop
    ST_DECODE,
    ST_OPER,  // Operand request outstanding
    ST_OPER_REL,
    ST_EXEC,
    ST_HALT
  } core_state_e;

  core_state_e state;
  logic [31:0] pc;
  logic [31:0] acc;
  logic [31:0] ir;  // Instruction register
  logic [31:0] operand_q;  // Memory operand or store echo
  logic [31:0] alu_result;
  logic [31:0] field_addr;
  logic [31:0] imm_sext;
  opcode_e op;

  assign op = opcode_e'(ir[31:28]);
  assign field_addr = {8'h00, ir[23:0]};
  assign imm_sext = {{8{ir[23]}}, ir[23:0]};

  cpu_alu u_alu (
    .op(op),
    .acc(acc),
    .operand(operand_q),
    .result(alu_result)
  );

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= ST_FETCH;
      pc <= RESET_PC;
      acc <= '0;
    end else begin
      case (state)
        ST_FETCH: begin
          if (ack) begin
            state <= ST_FETCH_REL;  // Drops req next cycle
          end
        end
        ST_FETCH_REL: begin
          if (!ack) begin
            state <= ST_DECODE;
          end
        end
        ST_DECODE: begin
          case (op)
            OP_LDI: begin
              acc <= imm_sext;
              pc <= pc + PC_STEP;
              state <= ST_FETCH;
            end
            OP_JNZ: begin
              pc <= (acc != '0) ? field_addr : pc + PC_STEP;
              state <= ST_FETCH;
            end
            OP_HALT: begin
              state <= ST_HALT;
            end
            OP_LOAD, OP_STORE, OP_ADD, OP_SUB, OP_AND, OP_XOR: begin
              state <= ST_OPER;  // Needs a second transaction
            end
            default: begin
              pc <= pc + PC_STEP;  // Unused opcodes act as no-ops
              state <= ST_FETCH;
            end
          endcase
        end
        ST_OPER: begin
          if (ack) begin
            state <= ST_OPER_REL;
          end
        end
        ST_OPER_REL: begin
          if (!ack) begin
            state <= ST_EXEC;
          end
        end
        ST_EXEC: begin
          acc <= alu_result;
          pc <= pc + PC_STEP;
          state <= ST_FETCH;
        end
        ST_HALT: begin
          state <= ST_HALT;  // Only reset leaves here
        end
        default: begin
          state <= ST_FETCH;
        end
      endcase
    end
  end

  // Capture response data while ack is high
  always_ff @(posedge clk) begin
    if (state == ST_FETCH && ack) begin
      ir <= bus_rsp.rdata;
    end
    if (state == ST_OPER && ack) begin
      operand_q <= bus_rsp.rdata;
    end
  end

  assign req = (state == ST_FETCH) || (state == ST_OPER);
  assign halted = (state == ST_HALT);

  // Request fields stay stable for the whole req phase
  always_comb begin
    bus_req.addr = pc;
    bus_req.write = 1'b0;
    bus_req.wdata = '0;
    if (state == ST_OPER) begin
      bus_req.addr = field_addr;
      bus_req.write = (op == OP_STORE);
      bus_req.wdata = (op == OP_STORE) ? acc : '0;
    end
  end

endmodule

// File: src/cpu_handler_top.sv
// CPU handler pin-level top
`timescale 1ns/100ps

module cpu_handler_top (
  input  logic       clk,
  input  logic       rst_n,
  input  logic [7:0] ui_in,
  input  logic [7:0] uio_in,
  output logic [7:0] uo_out,
  output logic [7:0] uio_out,
  output logic [7:0] uio_oe,
  input  logic       ena
);
  import cpu_pkg::*;

  logic req;
  logic ack;
  logic halted;
  bus_req_t bus_req;
  bus_rsp_t bus_rsp;
  logic unused_pins;

  cpu_core u_core (
    .clk(clk),
    .rst_n(rst_n),
    .req(req),
    .ack(ack),
    .bus_req(bus_req),
    .bus_rsp(bus_rsp),
    .halted(halted)
  );

  bus_bridge u_bridge (
    .clk(clk),
    .rst_n(rst_n),
    .req(req),
    .ack(ack),
    .bus_req(bus_req),
    .bus_rsp(bus_rsp),
    .halted(halted),
    .uo_out(uo_out),
    .uio_out(uio_out),
    .uio_oe(uio_oe),
    .uio_in(uio_in)
  );

  assign unused_pins = &{ui_in, ena, 1'b0};  // Dedicated inputs not used

endmodule

// File: src/cpu_pkg.sv
// CPU handler shared definitions
package cpu_pkg;

  // Pin frame constants
  localparam logic [7:0] FRAME_START = 8'h5A;
  localparam logic [7:0] IDLE_RUN = 8'h00;  // Idle byte while running
  localparam logic [7:0] IDLE_HALT = 8'hA5;  // Idle byte once halted
  localparam int CMD_WRITE_BIT = 0;  // Write flag position in command byte
  localparam logic [1:0] BEAT_LAST = 2'd3;  // Last of four byte beats

  // Core constants
  localparam logic [31:0] RESET_PC = 32'h0000_0000;
  localparam logic [31:0] PC_STEP = 32'd4;  // Word-sized instructions

  // Instruction word layout: [31:28] opcode, [27:24] spare, [23:0] imm or address
  typedef enum logic [3:0] {
    OP_HALT = 4'h0,  // Zero word stops the core
    OP_LDI = 4'h1,
    OP_LOAD = 4'h2,
    OP_STORE = 4'h3,
    OP_ADD = 4'h4,
    OP_SUB = 4'h5,
    OP_AND = 4'h6,
    OP_XOR = 4'h7,
    OP_JNZ = 4'h8
  } opcode_e;

  // Word request from core to bridge
  typedef struct packed {
    logic [31:0] addr;
    logic write;
    logic [31:0] wdata;
  } bus_req_t;

  // Response from bridge to core
  typedef struct packed {
    logic [31:0] rdata;
  } bus_rsp_t;

  // Bridge frame phases
  typedef enum logic [2:0] {
    PH_IDLE,
    PH_START,
    PH_ADDR,  // Four address and write-data beats
    PH_CMD,
    PH_READ,  // Four read-data beats
    PH_ACK
  } frame_phase_e;

endpackage

// File: tests/frame_checker.sv
// Pin frame checker
`timescale 1ns/100ps

module frame_checker (
  input logic       clk,
  input logic       rst_n,
  input logic [7:0] uo_out,
  input logic [7:0] uio_out,
  input logic [7:0] uio_oe
);
  import cpu_pkg::*;

  localparam int MIN_GAP = 2;  // Ack cycle plus req release

  logic [64:0] exp_q[$];  // {addr, write, wdata}
  int errors = 0;
  int frames = 0;
  int pos = 0;  // Position within a frame, 0 when outside
  int gap = MIN_GAP;
  logic halt_seen = 1'b0;
  logic [31:0] addr;
  logic [31:0] wdata;
  logic [7:0] oe_beat[4];
  logic [64:0] exp;

  task automatic expect_txn(input logic [31:0] a, input logic w, input logic [31:0] d);
    exp_q.push_back({a, w, d});
  endtask

  task automatic check_drained();
    if (exp_q.size() != 0) begin
      $display("Checker: %0d expected frames never appeared", exp_q.size());
      errors++;
      exp_q.delete();
    end
  endtask

  always @(negedge clk) begin
    if (!rst_n) begin
      pos = 0;
      gap = MIN_GAP;
      halt_seen = 1'b0;
      if (uo_out !== IDLE_RUN || uio_oe !== 8'h00) begin
        $display("MISMATCH %0t: reset pins uo_out=%h uio_oe=%h", $time, uo_out, uio_oe);
        errors++;
      end
    end else if (pos == 0) begin
      if (uio_oe !== 8'h00) begin
        $display("MISMATCH %0t: uio_oe=%h outside a frame", $time, uio_oe);
        errors++;
      end
      if (uo_out === FRAME_START) begin
        if (halt_seen) begin
          $display("Checker: frame started after the core halted at %0t", $time);
          errors++;
        end
        if (gap < MIN_GAP) begin
          $display("MISMATCH %0t: frame gap %0d cycles too short", $time, gap);
          errors++;
        end
        pos = 1;
      end else if (uo_out === IDLE_HALT) begin
        halt_seen = 1'b1;
        gap++;
      end else if (halt_seen) begin
        $display("MISMATCH %0t: uo_out=%h after halt, expected %h", $time, uo_out, IDLE_HALT);
        errors++;
        gap++;
      end else if (uo_out !== IDLE_RUN) begin
        $display("Checker: byte %h on uo_out without a start byte at %0t", uo_out, $time);
        errors++;
        gap++;
      end else begin
        gap++;
      end
    end else if (pos <= 4) begin
      addr[8*(pos-1) +: 8] = uo_out;
      wdata[8*(pos-1) +: 8] = uio_out;
      oe_beat[pos-1] = uio_oe;
      pos++;
    end else if (pos == 5) begin
      frames++;
      if (uo_out[7:1] !== 7'd0) begin
        $display("Checker: malformed command byte %h at %0t", uo_out, $time);
        errors++;
      end
      if (uio_out !== 8'h00 || uio_oe !== 8'h00) begin
        $display("MISMATCH %0t: command beat uio_out=%h uio_oe=%h", $time, uio_out, uio_oe);
        errors++;
      end
      for (int i = 0; i < 4; i++) begin
        if (oe_beat[i] !== {8{uo_out[CMD_WRITE_BIT]}}) begin
          $display("MISMATCH %0t: uio_oe=%h in address beat %0d", $time, oe_beat[i], i);
          errors++;
        end
      end
      if (exp_q.size() == 0) begin
        $display("Checker: unexpected frame to address %h at %0t", addr, $time);
        errors++;
      end else begin
        exp = exp_q.pop_front();
        if (addr !== exp[64:33] || uo_out[CMD_WRITE_BIT] !== exp[32]) begin
          $display("MISMATCH %0t: frame addr=%h write=%b, expected addr=%h write=%b",
                   $time, addr, uo_out[CMD_WRITE_BIT], exp[64:33], exp[32]);
          errors++;
        end else if (exp[32] && wdata !== exp[31:0]) begin
          $display("MISMATCH %0t: store to %h data=%h, expected %h",
                   $time, addr, wdata, exp[31:0]);
          errors++;
        end
      end
      pos++;
    end else begin
      if (uio_oe !== 8'h00 || uo_out !== IDLE_RUN) begin
        $display("MISMATCH %0t: read beat uo_out=%h uio_oe=%h", $time, uo_out, uio_oe);
        errors++;
      end
      pos = (pos == 9) ? 0 : pos + 1;
      gap = 0;
    end
  end

endmodule

// File: tests/tb_cpu_handler.sv
// CPU handler testbench
`timescale 1ns/100ps

module tb_cpu_handler;
  import cpu_pkg::*;

  localparam int NPROG = 3;
  localparam int MEM_WORDS = 128;  // Bytes 0x000 to 0x1FF
  localparam int DATA_BASE = 32;  // Data words from byte 0x80

  logic clk = 1'b0;
  logic rst_n = 1'b0;
  logic [7:0] ui_in = 8'h00;
  logic [7:0] uio_in = 8'h00;
  logic ena = 1'b1;
  logic [7:0] uo_out;
  logic [7:0] uio_out;
  logic [7:0] uio_oe;

  logic [31:0] mem[MEM_WORDS];  // External memory model
  logic [31:0] code_tab[NPROG][16];
  logic [31:0] data_tab[NPROG][8];
  int txn_total = 0;
  int cycles = 0;
  int cycle_limit = 1000000;
  int mpos = 0;
  logic [31:0] maddr;
  logic [31:0] mwdata;

  cpu_handler_top DUT (
    .clk(clk), .rst_n(rst_n), .ui_in(ui_in), .uio_in(uio_in),
    .uo_out(uo_out), .uio_out(uio_out), .uio_oe(uio_oe), .ena(ena)
  );

  frame_checker CHK (
    .clk(clk), .rst_n(rst_n), .uo_out(uo_out), .uio_out(uio_out), .uio_oe(uio_oe)
  );

  initial begin
    forever #2 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles > cycle_limit) begin
      $display("Timeout: core did not halt within %0d cycles", cycle_limit);
      $display("Done: errors found");
      $finish;
    end
  end

  // Memory side of the pin frame, driven 1 ns after the edge
  always @(posedge clk) begin
    #1;
    if (!rst_n) begin
      mpos = 0;
    end else if (mpos == 0) begin
      if (uo_out === FRAME_START) mpos = 1;
    end else begin
      if (mpos <= 4) begin
        maddr[8*(mpos-1) +: 8] = uo_out;
        mwdata[8*(mpos-1) +: 8] = uio_out;
      end else if (mpos == 5) begin
        if (uo_out[CMD_WRITE_BIT]) mem[maddr[8:2]] = mwdata;
      end else begin
        uio_in = mem[maddr[8:2]][8*(mpos-6) +: 8];
      end
      mpos = (mpos == 9) ? 0 : mpos + 1;
    end
  end

  function automatic logic [31:0] enc(opcode_e op, logic [23:0] field);
    return {op, 4'h0, field};
  endfunction

  task automatic load_memory(input int p);
    for (int i = 0; i < MEM_WORDS; i++) begin
      mem[i] = 32'h5a5a_0000 ^ (i * 4);  // Unused words are marked with their byte address
    end
    for (int i = 0; i < 16; i++) mem[i] = code_tab[p][i];
    for (int i = 0; i < 8; i++) mem[DATA_BASE + i] = data_tab[p][i];
  endtask

  // Reference ISA interpreter that queues expected frames in the checker when post is set
  task automatic model_program(input int p, input logic post, output int ntxn);
    logic [31:0] m[MEM_WORDS];
    logic [31:0] acc;
    logic [31:0] pc;
    logic [31:0] w;
    logic [31:0] fa;
    logic [31:0] opnd;
    opcode_e op;
    logic done;
    load_memory(p);
    m = mem;
    acc = '0;
    pc = RESET_PC;
    ntxn = 0;
    done = 1'b0;
    for (int step = 0; step < 500 && !done; step++) begin
      w = m[pc[8:2]];
      ntxn++;
      if (post) CHK.expect_txn(pc, 1'b0, 32'h0);
      op = opcode_e'(w[31:28]);
      fa = {8'h00, w[23:0]};
      case (op)
        OP_HALT: done = 1'b1;
        OP_LDI: begin
          acc = {{8{w[23]}}, w[23:0]};
          pc = pc + 4;
        end
        OP_JNZ: pc = (acc != 0) ? fa : pc + 4;
        OP_LOAD, OP_STORE, OP_ADD, OP_SUB, OP_AND, OP_XOR: begin
          ntxn++;
          if (post) CHK.expect_txn(fa, op == OP_STORE, (op == OP_STORE) ? acc : 32'h0);
          opnd = m[fa[8:2]];
          if (op == OP_STORE) m[fa[8:2]] = acc;
          else if (op == OP_LOAD) acc = opnd;
          else if (op == OP_ADD) acc = acc + opnd;
          else if (op == OP_SUB) acc = acc - opnd;
          else if (op == OP_AND) acc = acc & opnd;
          else acc = acc ^ opnd;
          pc = pc + 4;
        end
        default: pc = pc + 4;
      endcase
    end
  endtask

  initial begin
    int n;
    void'($urandom(32'hec13));
    for (int p = 0; p < NPROG; p++) begin
      for (int i = 0; i < 16; i++) code_tab[p][i] = enc(OP_HALT, 24'h0);
      for (int i = 0; i < 8; i++) data_tab[p][i] = $urandom;
    end
    // Negative immediate, then a single store
    code_tab[0][0] = enc(OP_LDI, 24'hFFF123);
    code_tab[0][1] = enc(OP_STORE, 24'h000100);
    // Memory operand arithmetic on random words
    code_tab[1][0] = enc(OP_LOAD, 24'h000080);
    code_tab[1][1] = enc(OP_ADD, 24'h000084);
    code_tab[1][2] = enc(OP_STORE, 24'h000104);
    code_tab[1][3] = enc(OP_SUB, 24'h000088);
    code_tab[1][4] = enc(OP_STORE, 24'h000108);
    code_tab[1][5] = enc(OP_AND, 24'h00008C);
    code_tab[1][6] = enc(OP_STORE, 24'h00010C);
    code_tab[1][7] = enc(OP_XOR, 24'h000090);
    code_tab[1][8] = enc(OP_STORE, 24'h000110);
    // Countdown loop through JNZ
    code_tab[2][0] = enc(OP_LDI, 24'h000003);
    code_tab[2][1] = enc(OP_STORE, 24'h000120);
    code_tab[2][2] = enc(OP_SUB, 24'h000094);
    code_tab[2][3] = enc(OP_JNZ, 24'h000004);
    data_tab[2][5] = 32'd1;  // Decrement step at 0x94

    for (int p = 0; p < NPROG; p++) begin
      model_program(p, 1'b0, n);
      txn_total += n;
    end
    cycle_limit = txn_total * 11 + txn_total * 4 + NPROG * 40 + 200;

    for (int p = 0; p < NPROG; p++) begin
      @(posedge clk);
      #1 rst_n = 1'b0;
      model_program(p, 1'b1, n);
      load_memory(p);
      repeat (4) @(posedge clk);
      #1 rst_n = 1'b1;
      while (uo_out !== IDLE_HALT) begin
        @(posedge clk);
        #1;
      end
      repeat (20) @(posedge clk);  // No frames may follow the halt
      CHK.check_drained();
    end

    $display("Summary: %0d frames checked, %0d checker errors", CHK.frames, CHK.errors);
    if (CHK.errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule
